// ==== arp_pkg.sv ====
/*
  Shared protocol constants and state types for the ARP responder.
  Only IPv4 over Ethernet is covered, so the lengths are fixed at 6 and 4.
*/
package arp_pkg;

    // ethernet and ARP protocol values
    localparam logic [15:0] eth_type_arp   = 16'h0806;
    localparam logic [15:0] arp_htype_eth  = 16'h0001;
    localparam logic [15:0] arp_ptype_ipv4 = 16'h0800;
    localparam logic [7:0]  arp_hlen_eth   = 8'd6;
    localparam logic [7:0]  arp_plen_ipv4  = 8'd4;

    // 28 byte ARP body fits in four 64-bit words
    localparam int arp_hdr_words = 4;

    typedef enum logic [15:0] {
        arp_oper_request = 16'd1,
        arp_oper_reply   = 16'd2
    } arp_oper_e;

    typedef enum logic [1:0] {
        rx_idle,
        rx_read_header,
        rx_wait_last
    } rx_state_e;

    typedef enum logic [1:0] {
        tx_idle,
        tx_header,
        tx_payload
    } tx_state_e;

endpackage

// ==== arp_eth_rx_64.sv ====
/*
  ARP receiver for a 64-bit Ethernet payload stream with parallel header fields.
  Payload byte 0 sits in tdata[7:0]; words past the ARP body are discarded.
  A frame with tuser set on its last word is dropped without an error flag.
  The next header is held off until the decoded frame has been taken.
*/
`timescale 1ns/1ps

module arp_eth_rx_64
    import arp_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    input  logic        in_hdr_valid,
    output logic        in_hdr_ready,
    input  logic [47:0] in_eth_dest_mac,
    input  logic [47:0] in_eth_src_mac,
    input  logic [15:0] in_eth_type,
    input  logic [63:0] in_tdata,
    input  logic [7:0]  in_tkeep,
    input  logic        in_tvalid,
    output logic        in_tready,
    input  logic        in_tlast,
    input  logic        in_tuser,

    output logic        out_frame_valid,
    input  logic        out_frame_ready,
    output logic [47:0] out_eth_dest_mac,
    output logic [47:0] out_eth_src_mac,
    output logic [15:0] out_eth_type,
    output logic [15:0] out_arp_htype,
    output logic [15:0] out_arp_ptype,
    output logic [7:0]  out_arp_hlen,
    output logic [7:0]  out_arp_plen,
    output logic [15:0] out_arp_oper,
    output logic [47:0] out_arp_sha,
    output logic [31:0] out_arp_spa,
    output logic [47:0] out_arp_tha,
    output logic [31:0] out_arp_tpa,

    output logic        busy,
    output logic        error_header_early_termination,
    output logic        error_invalid_header
);

    localparam logic [1:0] last_word = 2'(arp_hdr_words - 1);

    rx_state_e   state;
    rx_state_e   state_next;
    logic [1:0]  word_ptr;
    logic [1:0]  word_ptr_next;
    logic        hdr_ready_next;
    logic        tready_next;
    logic        valid_next;
    logic        early_next;
    logic        invalid_next;
    logic        store_hdr;
    logic        store_word;
    logic        beat;
    logic        lengths_ok;
    logic [63:0] data_be;

    assign beat = in_tvalid && in_tready;

    // hlen and plen come from word 0, already stored by the time tlast is seen
    assign lengths_ok = (out_arp_hlen == arp_hlen_eth) && (out_arp_plen == arp_plen_ipv4);

    // reverse byte order so wire byte 0 lands in the top byte
    assign data_be = {<<8{in_tdata}};

    always_comb begin
        state_next     = state;
        word_ptr_next  = word_ptr;
        hdr_ready_next = 1'b0;
        tready_next    = 1'b0;
        store_hdr      = 1'b0;
        store_word     = 1'b0;
        valid_next     = out_frame_valid && !out_frame_ready;
        early_next     = 1'b0;
        invalid_next   = 1'b0;

        case (state)
            rx_idle: begin
                word_ptr_next = '0;
                if (in_hdr_valid && in_hdr_ready) begin
                    store_hdr   = 1'b1;
                    tready_next = 1'b1;
                    state_next  = rx_read_header;
                end else begin
                    hdr_ready_next = !valid_next;
                end
            end
            rx_read_header: begin
                tready_next = 1'b1;
                if (beat) begin
                    store_word    = 1'b1;
                    word_ptr_next = word_ptr + 2'd1;
                    if (word_ptr == last_word) begin
                        state_next = rx_wait_last;
                    end
                end
            end
            default: begin
                // drain padding up to tlast
                tready_next = 1'b1;
            end
        endcase

        // end of frame decides between reply, error or silent drop
        if (state != rx_idle && beat && in_tlast) begin
            if (state == rx_read_header &&
                (word_ptr != last_word || in_tkeep[3:0] != 4'hF)) begin
                early_next = 1'b1;
            end else if (!lengths_ok) begin
                invalid_next = 1'b1;
            end else begin
                valid_next = !in_tuser;
            end
            hdr_ready_next = !valid_next;
            tready_next    = 1'b0;
            state_next     = rx_idle;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state                          <= rx_idle;
            word_ptr                       <= '0;
            in_hdr_ready                   <= 1'b0;
            in_tready                      <= 1'b0;
            out_frame_valid                <= 1'b0;
            busy                           <= 1'b0;
            error_header_early_termination <= 1'b0;
            error_invalid_header           <= 1'b0;
        end else begin
            state                          <= state_next;
            word_ptr                       <= word_ptr_next;
            in_hdr_ready                   <= hdr_ready_next;
            in_tready                      <= tready_next;
            out_frame_valid                <= valid_next;
            busy                           <= state_next != rx_idle;
            error_header_early_termination <= early_next;
            error_invalid_header           <= invalid_next;
        end
    end

    // field capture
    always_ff @(posedge clk) begin
        if (store_hdr) begin
            out_eth_dest_mac <= in_eth_dest_mac;
            out_eth_src_mac  <= in_eth_src_mac;
            out_eth_type     <= in_eth_type;
        end
        if (store_word) begin
            case (word_ptr)
                2'd0: begin
                    out_arp_htype <= data_be[63:48];
                    out_arp_ptype <= data_be[47:32];
                    out_arp_hlen  <= data_be[31:24];
                    out_arp_plen  <= data_be[23:16];
                    out_arp_oper  <= data_be[15:0];
                end
                2'd1: begin
                    out_arp_sha        <= data_be[63:16];
                    out_arp_spa[31:16] <= data_be[15:0];
                end
                2'd2: begin
                    out_arp_spa[15:0] <= data_be[63:48];
                    out_arp_tha       <= data_be[47:0];
                end
                default: begin
                    out_arp_tpa <= data_be[63:32];
                end
            endcase
        end
    end

    // a frame either completes or flags an error, never both
    assert property (@(posedge clk) disable iff (rst)
        $rose(out_frame_valid) |-> !error_header_early_termination && !error_invalid_header);

    assert property (@(posedge clk) disable iff (rst)
        out_frame_valid && !out_frame_ready |=> out_frame_valid &&
            $stable({out_eth_dest_mac, out_eth_src_mac, out_eth_type, out_arp_htype,
                     out_arp_ptype, out_arp_hlen, out_arp_plen, out_arp_oper,
                     out_arp_sha, out_arp_spa, out_arp_tha, out_arp_tpa}));

endmodule

// ==== arp_reply_builder.sv ====
/*
  Turns decoded ARP requests for the local IP into reply fields, one cycle later.
  Anything else is consumed and dropped. local_mac and local_ip are expected
  to stay constant while traffic flows.
*/
`timescale 1ns/1ps

module arp_reply_builder
    import arp_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic [47:0] local_mac,
    input  logic [31:0] local_ip,

    input  logic        in_frame_valid,
    output logic        in_frame_ready,
    input  logic [15:0] in_arp_htype,
    input  logic [15:0] in_arp_ptype,
    input  logic [15:0] in_arp_oper,
    input  logic [47:0] in_arp_sha,
    input  logic [31:0] in_arp_spa,
    input  logic [31:0] in_arp_tpa,

    output logic        out_frame_valid,
    input  logic        out_frame_ready,
    output logic [47:0] out_eth_dest_mac,
    output logic [47:0] out_eth_src_mac,
    output logic [15:0] out_eth_type,
    output logic [15:0] out_arp_htype,
    output logic [15:0] out_arp_ptype,
    output logic [7:0]  out_arp_hlen,
    output logic [7:0]  out_arp_plen,
    output logic [15:0] out_arp_oper,
    output logic [47:0] out_arp_sha,
    output logic [31:0] out_arp_spa,
    output logic [47:0] out_arp_tha,
    output logic [31:0] out_arp_tpa
);

    logic accept;
    logic is_ours;

    assign in_frame_ready = !out_frame_valid || out_frame_ready;
    assign accept         = in_frame_valid && in_frame_ready;

    assign is_ours = (in_arp_oper == arp_oper_request) && (in_arp_htype == arp_htype_eth) &&
                     (in_arp_ptype == arp_ptype_ipv4) && (in_arp_tpa == local_ip);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_frame_valid <= 1'b0;
        end else if (accept) begin
            out_frame_valid <= is_ours;
        end else if (out_frame_ready) begin
            out_frame_valid <= 1'b0;
        end
    end

    // reply goes back to the requester
    always_ff @(posedge clk) begin
        if (accept && is_ours) begin
            out_eth_dest_mac <= in_arp_sha;
            out_eth_src_mac  <= local_mac;
            out_eth_type     <= eth_type_arp;
            out_arp_htype    <= arp_htype_eth;
            out_arp_ptype    <= arp_ptype_ipv4;
            out_arp_hlen     <= arp_hlen_eth;
            out_arp_plen     <= arp_plen_ipv4;
            out_arp_oper     <= arp_oper_reply;
            out_arp_sha      <= local_mac;
            out_arp_spa      <= local_ip;
            out_arp_tha      <= in_arp_sha;
            out_arp_tpa      <= in_arp_spa;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        out_frame_valid && !out_frame_ready |=> out_frame_valid);

endmodule

// ==== arp_eth_tx_64.sv ====
/*
  Serializes ARP reply fields into an Ethernet header and four 64-bit words.
  No padding to the 60 byte minimum; word 3 carries only its low four bytes.
  New fields are taken only once the previous frame has fully left.
*/
`timescale 1ns/1ps

module arp_eth_tx_64
    import arp_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    input  logic        in_frame_valid,
    output logic        in_frame_ready,
    input  logic [47:0] in_eth_dest_mac,
    input  logic [47:0] in_eth_src_mac,
    input  logic [15:0] in_eth_type,
    input  logic [15:0] in_arp_htype,
    input  logic [15:0] in_arp_ptype,
    input  logic [7:0]  in_arp_hlen,
    input  logic [7:0]  in_arp_plen,
    input  logic [15:0] in_arp_oper,
    input  logic [47:0] in_arp_sha,
    input  logic [31:0] in_arp_spa,
    input  logic [47:0] in_arp_tha,
    input  logic [31:0] in_arp_tpa,

    output logic        out_hdr_valid,
    input  logic        out_hdr_ready,
    output logic [47:0] out_eth_dest_mac,
    output logic [47:0] out_eth_src_mac,
    output logic [15:0] out_eth_type,
    output logic [63:0] out_tdata,
    output logic [7:0]  out_tkeep,
    output logic        out_tvalid,
    input  logic        out_tready,
    output logic        out_tlast,
    output logic        out_tuser,

    output logic        busy
);

    localparam logic [1:0] last_word = 2'(arp_hdr_words - 1);

    tx_state_e   state;
    logic [1:0]  word_ptr;
    logic [15:0] htype;
    logic [15:0] ptype;
    logic [7:0]  hlen;
    logic [7:0]  plen;
    arp_oper_e   oper;
    logic [47:0] sha;
    logic [31:0] spa;
    logic [47:0] tha;
    logic [31:0] tpa;
    logic [255:0] body;
    logic [63:0] word_be;

    assign in_frame_ready = state == tx_idle;
    assign out_hdr_valid  = state == tx_header;
    assign out_tvalid     = state == tx_payload;
    assign busy           = state != tx_idle;

    // 28 body bytes, big-endian, zero filled to 32
    assign body      = {htype, ptype, hlen, plen, oper, sha, spa, tha, tpa, 32'h0};
    assign word_be   = body[255 - 64 * word_ptr -: 64];
    assign out_tdata = {<<8{word_be}};
    assign out_tkeep = (word_ptr == last_word) ? 8'h0F : 8'hFF;
    assign out_tlast = word_ptr == last_word;
    assign out_tuser = 1'b0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= tx_idle;
            word_ptr <= '0;
        end else begin
            case (state)
                tx_idle: begin
                    if (in_frame_valid) begin
                        state <= tx_header;
                    end
                end
                tx_header: begin
                    if (out_hdr_ready) begin
                        state    <= tx_payload;
                        word_ptr <= '0;
                    end
                end
                default: begin
                    if (out_tready) begin
                        word_ptr <= word_ptr + 2'd1;
                        if (word_ptr == last_word) begin
                            state <= tx_idle;
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (in_frame_valid && in_frame_ready) begin
            out_eth_dest_mac <= in_eth_dest_mac;
            out_eth_src_mac  <= in_eth_src_mac;
            out_eth_type     <= in_eth_type;
            htype            <= in_arp_htype;
            ptype            <= in_arp_ptype;
            hlen             <= in_arp_hlen;
            plen             <= in_arp_plen;
            oper             <= arp_oper_e'(in_arp_oper);
            sha              <= in_arp_sha;
            spa              <= in_arp_spa;
            tha              <= in_arp_tha;
            tpa              <= in_arp_tpa;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        out_tvalid && !out_tready |=> out_tvalid && $stable(out_tdata));

endmodule

// ==== arp_responder_64.sv ====
/*
  ARP responder: receiver, reply builder and transmitter in a chain.
  Every input frame is treated as ARP; there is no ethertype filter in front.
*/
`timescale 1ns/1ps

module arp_responder_64 (
    input  logic        clk,
    input  logic        rst,
    input  logic [47:0] local_mac,
    input  logic [31:0] local_ip,

    input  logic        in_hdr_valid,
    output logic        in_hdr_ready,
    input  logic [47:0] in_eth_dest_mac,
    input  logic [47:0] in_eth_src_mac,
    input  logic [15:0] in_eth_type,
    input  logic [63:0] in_tdata,
    input  logic [7:0]  in_tkeep,
    input  logic        in_tvalid,
    output logic        in_tready,
    input  logic        in_tlast,
    input  logic        in_tuser,

    output logic        out_hdr_valid,
    input  logic        out_hdr_ready,
    output logic [47:0] out_eth_dest_mac,
    output logic [47:0] out_eth_src_mac,
    output logic [15:0] out_eth_type,
    output logic [63:0] out_tdata,
    output logic [7:0]  out_tkeep,
    output logic        out_tvalid,
    input  logic        out_tready,
    output logic        out_tlast,
    output logic        out_tuser,

    output logic        rx_busy,
    output logic        tx_busy,
    output logic        error_header_early_termination,
    output logic        error_invalid_header
);

    // decoded request
    logic        req_valid;
    logic        req_ready;
    logic [15:0] req_htype;
    logic [15:0] req_ptype;
    logic [15:0] req_oper;
    logic [47:0] req_sha;
    logic [31:0] req_spa;
    logic [31:0] req_tpa;

    // reply fields
    logic        rep_valid;
    logic        rep_ready;
    logic [47:0] rep_eth_dest_mac;
    logic [47:0] rep_eth_src_mac;
    logic [15:0] rep_eth_type;
    logic [15:0] rep_htype;
    logic [15:0] rep_ptype;
    logic [7:0]  rep_hlen;
    logic [7:0]  rep_plen;
    logic [15:0] rep_oper;
    logic [47:0] rep_sha;
    logic [31:0] rep_spa;
    logic [47:0] rep_tha;
    logic [31:0] rep_tpa;

    // ethernet header, lengths and tha of a request play no part in the reply
    arp_eth_rx_64 i_rx (
        .clk, .rst,
        .in_hdr_valid, .in_hdr_ready, .in_eth_dest_mac, .in_eth_src_mac, .in_eth_type,
        .in_tdata, .in_tkeep, .in_tvalid, .in_tready, .in_tlast, .in_tuser,
        .out_frame_valid(req_valid), .out_frame_ready(req_ready),
        .out_eth_dest_mac(), .out_eth_src_mac(), .out_eth_type(),
        .out_arp_htype(req_htype), .out_arp_ptype(req_ptype),
        .out_arp_hlen(), .out_arp_plen(), .out_arp_oper(req_oper),
        .out_arp_sha(req_sha), .out_arp_spa(req_spa),
        .out_arp_tha(), .out_arp_tpa(req_tpa),
        .busy(rx_busy), .error_header_early_termination, .error_invalid_header
    );

    arp_reply_builder i_builder (
        .clk, .rst, .local_mac, .local_ip,
        .in_frame_valid(req_valid), .in_frame_ready(req_ready),
        .in_arp_htype(req_htype), .in_arp_ptype(req_ptype), .in_arp_oper(req_oper),
        .in_arp_sha(req_sha), .in_arp_spa(req_spa), .in_arp_tpa(req_tpa),
        .out_frame_valid(rep_valid), .out_frame_ready(rep_ready),
        .out_eth_dest_mac(rep_eth_dest_mac), .out_eth_src_mac(rep_eth_src_mac),
        .out_eth_type(rep_eth_type), .out_arp_htype(rep_htype), .out_arp_ptype(rep_ptype),
        .out_arp_hlen(rep_hlen), .out_arp_plen(rep_plen), .out_arp_oper(rep_oper),
        .out_arp_sha(rep_sha), .out_arp_spa(rep_spa),
        .out_arp_tha(rep_tha), .out_arp_tpa(rep_tpa)
    );

    arp_eth_tx_64 i_tx (
        .clk, .rst,
        .in_frame_valid(rep_valid), .in_frame_ready(rep_ready),
        .in_eth_dest_mac(rep_eth_dest_mac), .in_eth_src_mac(rep_eth_src_mac),
        .in_eth_type(rep_eth_type), .in_arp_htype(rep_htype), .in_arp_ptype(rep_ptype),
        .in_arp_hlen(rep_hlen), .in_arp_plen(rep_plen), .in_arp_oper(rep_oper),
        .in_arp_sha(rep_sha), .in_arp_spa(rep_spa),
        .in_arp_tha(rep_tha), .in_arp_tpa(rep_tpa),
        .out_hdr_valid, .out_hdr_ready, .out_eth_dest_mac, .out_eth_src_mac, .out_eth_type,
        .out_tdata, .out_tkeep, .out_tvalid, .out_tready, .out_tlast, .out_tuser,
        .busy(tx_busy)
    );

endmodule

// ==== tb_clock_gen.sv ====
/*
  Testbench clock and reset. 100 ns period, first rising edge at 50 ns.
  Reset is high for the first four clock periods and drops on a falling edge.
*/
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // falls at 400 ns, away from the rising edges
    initial begin
        rst = 1'b1;
        #400 rst = 1'b0;
    end

endmodule

// ==== tb_arp_responder_64.sv ====
/*
  Testbench for the ARP responder. Inputs change 1 ns after the rising edge,
  outputs are sampled on the falling edge. Output ready signals follow an LFSR.
  Expected replies are derived from the request bytes and checked in order.
*/
`timescale 1ns/1ps

module tb_arp_responder_64;

    typedef struct packed {
        logic [47:0]  dest;
        logic [255:0] body;
    } reply_t;

    localparam int wait_limit = 2000;

    logic        clk;
    logic        rst;
    logic [47:0] local_mac = 48'h02_00_5e_10_20_30;
    logic [31:0] local_ip = 32'hc0a8_0a01;
    logic        in_hdr_valid, in_hdr_ready, in_tvalid, in_tready, in_tlast, in_tuser;
    logic [47:0] in_eth_dest_mac, in_eth_src_mac;
    logic [15:0] in_eth_type;
    logic [63:0] in_tdata;
    logic [7:0]  in_tkeep;
    logic        out_hdr_valid, out_hdr_ready, out_tvalid, out_tready, out_tlast, out_tuser;
    logic [47:0] out_eth_dest_mac, out_eth_src_mac;
    logic [15:0] out_eth_type;
    logic [63:0] out_tdata;
    logic [7:0]  out_tkeep;
    logic        rx_busy, tx_busy, error_header_early_termination, error_invalid_header;

    // scoreboard, written by the stimulus and read by the monitor
    reply_t      exp_mem [0:7];
    int          exp_wr = 0;
    int          exp_rd = 0;
    reply_t      cur;
    logic        reply_open = 1'b0;
    logic        hold_prev = 1'b0;
    logic [63:0] hold_data;
    logic [63:0] mask;
    int          word_idx = 0;
    int          replies_done = 0;
    int          early_cnt = 0;
    int          invalid_cnt = 0;
    int          mon_errors = 0;
    int          flow_errors = 0;
    int          timeouts = 0;
    logic [31:0] lfsr;

    tb_clock_gen i_clock_gen (.clk, .rst);

    arp_responder_64 i_dut (.*);

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // 28 byte ARP body, big-endian, zero filled to 32 bytes
    function automatic logic [255:0] arp_body(input logic [15:0] oper, input logic [7:0] hlen,
            input logic [47:0] sha, input logic [31:0] spa,
            input logic [47:0] tha, input logic [31:0] tpa);
        return {16'h0001, 16'h0800, hlen, 8'd4, oper, sha, spa, tha, tpa, 32'h0};
    endfunction

    // wire byte 0 of each word goes to tdata[7:0]
    function automatic logic [63:0] wire_word(input logic [255:0] body, input int w);
        logic [63:0] d;
        d = '0;
        for (int j = 0; j < 8; j++) begin
            d[8*j +: 8] = body[255 - 8*(8*w + j) -: 8];
        end
        return d;
    endfunction

    task automatic check(inout int errs, input string name, input logic [63:0] expected,
            input logic [63:0] actual);
        assert (expected == actual) else begin
            errs++;
            $display("mismatch %s: expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic finish_run();
        $display("errors: %0d in replies, %0d in flow checks, %0d timeouts",
                 mon_errors, flow_errors, timeouts);
        if (mon_errors + flow_errors + timeouts == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    endtask

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic step_wait(inout int cnt, input string what);
        tick();
        cnt++;
        if (cnt > wait_limit) begin
            timeouts++;
            $display("timeout while waiting for %s", what);
            finish_run();
        end
    endtask

    task automatic send_frame(input logic [47:0] src_mac, input logic [255:0] body,
            input int n_words, input logic bad_user);
        int cnt;
        in_hdr_valid    = 1'b1;
        in_eth_dest_mac = 48'hffff_ffff_ffff;
        in_eth_src_mac  = src_mac;
        in_eth_type     = 16'h0806;
        cnt = 0;
        while (!in_hdr_ready) step_wait(cnt, "in_hdr_ready");
        tick();
        in_hdr_valid = 1'b0;
        for (int w = 0; w < n_words; w++) begin
            in_tvalid = 1'b1;
            in_tdata  = (w < 4) ? wire_word(body, w) : {32'hfeed_0000, 32'(w)};
            in_tkeep  = (w == 3 && n_words == 4) ? 8'h0F : 8'hFF;
            in_tlast  = (w == n_words - 1);
            in_tuser  = bad_user && (w == n_words - 1);
            cnt = 0;
            while (!in_tready) step_wait(cnt, "in_tready");
            tick();
        end
        in_tvalid = 1'b0;
        in_tlast  = 1'b0;
        in_tuser  = 1'b0;
    endtask

    // only a well formed request for local_ip that ends cleanly gets a reply
    task automatic send_request(input logic [47:0] sha, input logic [31:0] spa,
            input logic [31:0] tpa, input logic [15:0] oper, input logic [7:0] hlen,
            input int n_words, input logic bad_user);
        logic expect_reply;
        expect_reply = (oper == 16'h0001) && (tpa == local_ip) && (hlen == 8'd6) &&
                       (n_words >= 4) && !bad_user;
        if (expect_reply) begin
            exp_mem[exp_wr % 8] = '{sha, arp_body(16'h0002, 8'd6, local_mac, local_ip,
                                                  sha, spa)};
            exp_wr++;
        end
        send_frame(sha, arp_body(oper, hlen, sha, spa, 48'h0, tpa), n_words, bad_user);
    endtask

    // back-pressure, one LFSR step per bit
    initial begin
        out_tready    = 1'b0;
        out_hdr_ready = 1'b0;
        lfsr          = 32'ha0ae01ce;
        forever begin
            @(posedge clk);
            #1;
            lfsr          = lfsr_step(lfsr);
            out_tready    = lfsr[0];
            lfsr          = lfsr_step(lfsr);
            out_hdr_ready = lfsr[0];
        end
    end

    // output monitor
    always @(negedge clk) begin
        if (error_header_early_termination) early_cnt++;
        if (error_invalid_header) invalid_cnt++;
        if (hold_prev) begin
            assert (out_tvalid && out_tdata == hold_data) else begin
                mon_errors++;
                $display("mismatch stall hold: expected %h actual %h", hold_data, out_tdata);
            end
        end
        hold_prev = out_tvalid && !out_tready;
        hold_data = out_tdata;
        if (out_hdr_valid && out_hdr_ready) begin
            assert (exp_rd < exp_wr && !reply_open) else begin
                mon_errors++;
                $display("reply header seen while no reply was expected");
            end
            cur = exp_mem[exp_rd % 8];
            exp_rd++;
            check(mon_errors, "reply eth_dest_mac", 64'(cur.dest), 64'(out_eth_dest_mac));
            check(mon_errors, "reply eth_src_mac", 64'(local_mac), 64'(out_eth_src_mac));
            check(mon_errors, "reply eth_type", 64'h0806, 64'(out_eth_type));
            reply_open = 1'b1;
            word_idx   = 0;
        end
        if (out_tvalid && out_tready) begin
            assert (reply_open && word_idx < 4) else begin
                mon_errors++;
                $display("payload word outside a four word reply");
            end
            if (reply_open && word_idx < 4) begin
                // only the low four bytes of word 3 are valid
                mask = (word_idx == 3) ? 64'h0000_0000_ffff_ffff : '1;
                check(mon_errors, "reply tdata", wire_word(cur.body, word_idx) & mask,
                      out_tdata & mask);
                check(mon_errors, "reply tkeep", (word_idx == 3) ? 64'h0F : 64'hFF,
                      64'(out_tkeep));
                check(mon_errors, "reply tlast", 64'(word_idx == 3), 64'(out_tlast));
                check(mon_errors, "reply tuser", 64'h0, 64'(out_tuser));
            end
            word_idx++;
            if (out_tlast) begin
                reply_open = 1'b0;
                replies_done++;
            end
        end
    end

    initial begin : stimulus
        int cnt;
        in_hdr_valid    = 1'b0;
        in_eth_dest_mac = '0;
        in_eth_src_mac  = '0;
        in_eth_type     = '0;
        in_tdata        = '0;
        in_tkeep        = '0;
        in_tvalid       = 1'b0;
        in_tlast        = 1'b0;
        in_tuser        = 1'b0;
        tick();
        cnt = 0;
        while (rst) step_wait(cnt, "reset release");

        // idle outputs after reset
        for (int i = 0; i < 3; i++) begin
            check(flow_errors, "idle after reset", 64'h0,
                  {58'h0, out_hdr_valid, out_tvalid, rx_busy, tx_busy,
                   error_header_early_termination, error_invalid_header});
            tick();
        end

        // plain requests under random back-pressure
        send_request(48'h0a_11_22_33_44_01, 32'h0a00_0001, local_ip, 16'h0001, 8'd6, 4, 1'b0);
        send_request(48'h0a_11_22_33_44_02, 32'h0a00_0002, local_ip, 16'h0001, 8'd6, 4, 1'b0);
        send_request(48'h0a_11_22_33_44_03, 32'h0a00_0003, local_ip, 16'h0001, 8'd6, 4, 1'b0);
        cnt = 0;
        while (replies_done < 3) step_wait(cnt, "first three replies");

        // other IP, then an incoming reply, each followed by a good request
        send_request(48'h0a_11_22_33_44_04, 32'h0a00_0004, 32'hc0a8_0a02, 16'h0001,
                     8'd6, 4, 1'b0);
        send_request(48'h0a_11_22_33_44_05, 32'h0a00_0005, local_ip, 16'h0001, 8'd6, 4, 1'b0);
        send_request(48'h0a_11_22_33_44_06, 32'h0a00_0006, local_ip, 16'h0002, 8'd6, 4, 1'b0);
        send_request(48'h0a_11_22_33_44_07, 32'h0a00_0007, local_ip, 16'h0001, 8'd6, 4, 1'b0);
        cnt = 0;
        while (replies_done < 5) step_wait(cnt, "replies after filtered frames");

        // tlast on word 2
        send_request(48'h0a_11_22_33_44_08, 32'h0a00_0008, local_ip, 16'h0001, 8'd6, 3, 1'b0);
        cnt = 0;
        while (early_cnt == 0) step_wait(cnt, "error_header_early_termination");
        check(flow_errors, "invalid flag after early frame", 64'h0, 64'(invalid_cnt));

        // hlen 5
        send_request(48'h0a_11_22_33_44_09, 32'h0a00_0009, local_ip, 16'h0001, 8'd5, 4, 1'b0);
        cnt = 0;
        while (invalid_cnt == 0) step_wait(cnt, "error_invalid_header");
        check(flow_errors, "early flag after bad hlen", 64'h1, 64'(early_cnt));

        // padded frame with tuser on its last word, then a good request
        send_request(48'h0a_11_22_33_44_0a, 32'h0a00_000a, local_ip, 16'h0001, 8'd6, 6, 1'b1);
        send_request(48'h0a_11_22_33_44_0b, 32'h0a00_000b, local_ip, 16'h0001, 8'd6, 4, 1'b0);
        cnt = 0;
        while (replies_done < exp_wr) step_wait(cnt, "last reply");

        check(flow_errors, "reply count", 64'(exp_wr), 64'(replies_done));
        check(flow_errors, "early termination pulses", 64'h1, 64'(early_cnt));
        check(flow_errors, "invalid header pulses", 64'h1, 64'(invalid_cnt));
        finish_run();
    end

endmodule

// ==== project.f ====
arp_pkg.sv
arp_eth_rx_64.sv
arp_reply_builder.sv
arp_eth_tx_64.sv
arp_responder_64.sv
tb_clock_gen.sv
tb_arp_responder_64.sv

// ==== run.sh ====
#!/bin/sh
# build and run the ARP responder testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module tb_arp_responder_64 -o sim_arp

status=0
./obj_dir/sim_arp > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "sim failed" sim.log; then
    exit 1
fi
exit 0
